// ==== compile.f ====
+incdir+hw
hw/ks10_pkg.sv
hw/specDecode.sv
hw/apr.sv
hw/piArbiter.sv
hw/aprSubsystem.sv
tests/aprSubsystem_checker.sv
tests/aprSubsystem_tb.sv

// ==== Makefile ====
TOP = aprSubsystem_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== tests/aprSubsystem_tb.sv ====
`include "ks10_macros.svh"

module aprSubsystem_tb;

   import ks10_pkg::*;

   localparam int SelWidth   = `CROM_SPEC_SEL_LO - `CROM_SPEC_SEL_HI + 1;
   localparam int RandCycles = 400;
   localparam int WaitLimit  = 20;

   logic                   clk;
   logic                   rst;
   logic                   clken;
   logic [0:`CROM_WIDTH-1] crom;
   dpWord_t                dp;
   logic                   nxmIntr;
   logic                   cslIntr;
   logic [1:7]             devIntr;
   logic [22:35]           aprFlags;
   logic [1:7]             aprIntr;
   logic                   piReq;
   logic [0:2]             piLevel;

   logic [31:0] seed = 32'h157f_d660;
   int          timeouts = 0;
   int          errors;
   dpWord_t     word;

   aprSubsystem u_aprSubsystem (.clk(clk), .rst(rst), .clken(clken), .crom(crom), .dp(dp),
                                .nxmIntr(nxmIntr), .cslIntr(cslIntr), .devIntr(devIntr),
                                .aprFlags(aprFlags), .aprIntr(aprIntr), .piReq(piReq),
                                .piLevel(piLevel));

   bind aprSubsystem aprSubsystem_checker u_checker (.clk(clk), .rst(rst), .clken(clken),
      .crom(crom), .dp(dp), .nxmIntr(nxmIntr), .cslIntr(cslIntr), .devIntr(devIntr),
      .aprFlags(aprFlags), .aprIntr(aprIntr), .piReq(piReq), .piLevel(piLevel));

   ////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////

   // LCG, upper bits are the useful ones
   function automatic logic [31:0] nextRandom();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic driveSpecial(input logic en, input logic [0:SelWidth-1] sel);
      crom = '0;
      crom[`CROM_SPEC_EN] = en;
      crom[`CROM_SPEC_SEL_HI:`CROM_SPEC_SEL_LO] = sel;
   endtask

   // One cycle write, special field off afterwards
   task automatic writeReg(input logic [0:SelWidth-1] sel, input dpWord_t value);
      @(negedge clk);
      clken = 1'b1;
      dp = value;
      driveSpecial(1'b1, sel);
      @(negedge clk);
      driveSpecial(1'b0, '0);
   endtask

   task automatic waitForLevel(input logic [0:2] level, input string what);
      int cycles;
      cycles = 0;
      while (piLevel !== level && cycles < WaitLimit)
      begin
         @(negedge clk);
         cycles++;
      end
      if (piLevel !== level)
      begin
         timeouts++;
         $display("Timeout waiting for %s", what);
      end
   endtask

   task automatic randomCycle();
      logic [31:0]         r;
      logic [31:0]         d;
      logic [31:0]         e;
      logic [0:SelWidth-1] sel;
      @(negedge clk);
      r = nextRandom();
      d = nextRandom();
      e = nextRandom();
      case (r[31:30])
         2'd0:    sel = `SPEC_SEL_APRENABLE;
         2'd1:    sel = `SPEC_SEL_APRFLAGS;
         2'd2:    sel = `SPEC_SEL_PIENABLE;
         default: sel = r[29:24];
      endcase
      clken = (r[23:22] != 2'b00);
      driveSpecial(r[21] | r[20], sel);
      dp = {d, e[31:28]};
      // PI mostly on so the arbiter sees traffic
      if (sel == `SPEC_SEL_PIENABLE)
         dp.piView.piOn = e[27] | e[26];
      nxmIntr = (e[25:22] == 4'h0);
      cslIntr = (e[21:18] == 4'h0);
      devIntr = r[19:13] & e[17:11];
   endtask

   ////////////////////////////////////////////////////////////////////
   // Clock and stimulus
   ////////////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      rst = 1'b1;
      clken = 1'b0;
      crom = '0;
      dp = '0;
      nxmIntr = 1'b0;
      cslIntr = 1'b0;
      devIntr = '0;
      repeat (3) @(negedge clk);
      rst = 1'b0;

      // PI on, every level enabled
      word = '0;
      word.piView.piOn = 1'b1;
      word.piView.levelEn = '1;
      writeReg(`SPEC_SEL_PIENABLE, word);

      // All flags enabled, request on level 3
      word = '0;
      word.aprEnView.mask = '1;
      word.aprEnView.pri = 3'd3;
      writeReg(`SPEC_SEL_APRENABLE, word);

      // Flag write of zero together with a memory event
      @(negedge clk);
      dp = '0;
      driveSpecial(1'b1, `SPEC_SEL_APRFLAGS);
      nxmIntr = 1'b1;
      @(negedge clk);
      driveSpecial(1'b0, '0);
      nxmIntr = 1'b0;
      waitForLevel(3'd3, "APR request on level 3");

      // Console event while clken is low
      @(negedge clk);
      clken = 1'b0;
      cslIntr = 1'b1;
      @(negedge clk);
      cslIntr = 1'b0;
      clken = 1'b1;

      // Device on level 1 beats the APR
      devIntr = 7'b1000000;
      waitForLevel(3'd1, "device request on level 1");
      devIntr = '0;

      repeat (RandCycles) randomCycle();

      // Reset in the middle of traffic
      @(negedge clk);
      rst = 1'b1;
      repeat (3) @(negedge clk);
      rst = 1'b0;

      // Software interrupt on level 5
      word = '0;
      word.piView.piOn = 1'b1;
      word.piView.levelEn = '1;
      writeReg(`SPEC_SEL_PIENABLE, word);
      word = '0;
      word.aprEnView.swInt = 1'b1;
      word.aprEnView.pri = 3'd5;
      writeReg(`SPEC_SEL_APRENABLE, word);
      devIntr = '0;
      nxmIntr = 1'b0;
      cslIntr = 1'b0;
      waitForLevel(3'd5, "software interrupt on level 5");

      repeat (RandCycles) randomCycle();

      @(negedge clk);
      errors = u_aprSubsystem.u_checker.failCount + timeouts;
      $display("Assertion failures: %0d, timeouts: %0d",
               u_aprSubsystem.u_checker.failCount, timeouts);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== tests/aprSubsystem_checker.sv ====
`include "ks10_macros.svh"

// Bound into aprSubsystem and fed from its ports only
module aprSubsystem_checker
(
   input logic                    clk,
   input logic                    rst,
   input logic                    clken,
   input logic [0:`CROM_WIDTH-1]  crom,
   input logic [0:35]             dp,
   input logic                    nxmIntr,
   input logic                    cslIntr,
   input logic [1:7]              devIntr,
   input logic [22:35]            aprFlags,
   input logic [1:7]              aprIntr,
   input logic                    piReq,
   input logic [0:2]              piLevel
);

   localparam int SelWidth = `CROM_SPEC_SEL_LO - `CROM_SPEC_SEL_HI + 1;

   // Strobes as the special field defines them
   logic                specHit;
   logic [0:SelWidth-1] specSel;
   logic                enWr;
   logic                flagsWr;
   logic                piWr;

   // Shadows of registers not visible at the ports
   logic [24:31] enMask;
   logic         swInt;
   logic [0:2]   pri;
   logic         piOn;
   logic [1:7]   levelEn;

   // Expected values
   logic [22:31] nextRegs;
   logic [22:31] expRegs;
   logic         expReq;
   logic [1:7]   expIntr;
   logic [1:7]   pending;
   logic [0:2]   expLevel;
   logic [0:2]   expLevelQ;

   // Previous cycle
   logic         rstSeen;
   logic         clkenQ;
   logic         prevReq;
   logic [0:2]   prevLevel;

   int failCount = 0;

   ////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////

   assign specHit = clken & crom[`CROM_SPEC_EN];
   assign specSel = crom[`CROM_SPEC_SEL_HI:`CROM_SPEC_SEL_LO];
   assign enWr    = specHit && (specSel == `SPEC_SEL_APRENABLE);
   assign flagsWr = specHit && (specSel == `SPEC_SEL_APRFLAGS);
   assign piWr    = specHit && (specSel == `SPEC_SEL_PIENABLE);

   // Trap, paging and flags after this edge
   // Events win over a flag write
   always_comb
   begin
      nextRegs = expRegs;
      if (enWr)
         nextRegs[22:23] = dp[22:23];
      if (flagsWr)
         nextRegs[24:31] = dp[24:31];
      if (nxmIntr)
         nextRegs[27] = 1'b1;
      if (cslIntr)
         nextRegs[31] = 1'b1;
   end

   // Request and its level
   always_comb
   begin
      expReq  = (|(expRegs[24:31] & enMask)) | swInt;
      expIntr = '0;
      if (expReq && pri != 3'd0)
         expIntr[pri] = 1'b1;
   end

   // First active level counting up from 1
   always_comb
   begin
      pending  = piOn ? ((expIntr | devIntr) & levelEn) : 7'd0;
      expLevel = 3'd0;
      for (int lvl = 1; lvl <= 7; lvl++)
      begin
         if (pending[lvl] && expLevel == 3'd0)
            expLevel = 3'(lvl);
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         enMask    <= '0;
         swInt     <= 1'b0;
         pri       <= '0;
         piOn      <= 1'b0;
         levelEn   <= '0;
         expRegs   <= '0;
         expLevelQ <= '0;
         clkenQ    <= 1'b0;
         prevReq   <= 1'b0;
         prevLevel <= '0;
      end
      else
      begin
         if (enWr)
         begin
            enMask <= dp[24:31];
            swInt  <= dp[32];
            pri    <= dp[33:35];
         end
         if (piWr)
         begin
            piOn    <= dp[27];
            levelEn <= dp[29:35];
         end
         expRegs   <= nextRegs;
         expLevelQ <= expLevel;
         clkenQ    <= clken;
         prevReq   <= piReq;
         prevLevel <= piLevel;
      end
   end

   // Marks the edge right after reset too
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rstSeen <= 1'b1;
      else
         rstSeen <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////
   // Assertions
   ////////////////////////////////////////////////////////////////////

   resetValues: assert property (@(posedge clk)
      rstSeen |-> (aprFlags == 14'b111 && aprIntr == 7'd0 && !piReq && piLevel == 3'd0))
      else
      begin
         failCount++;
         $error("Error %0t aprFlags/aprIntr/piReq/piLevel expected 0007/00/0/0 got %h/%h/%b/%0d",
                $time, $sampled(aprFlags), $sampled(aprIntr), $sampled(piReq), $sampled(piLevel));
      end

   // Writes, holds and event sets
   regUpdate: assert property (@(posedge clk) disable iff (rst) aprFlags[22:31] == expRegs)
      else
      begin
         failCount++;
         $error("Error %0t aprFlags[22:31] expected %h got %h",
                $time, $sampled(expRegs), $sampled(aprFlags[22:31]));
      end

   aprRequest: assert property (@(posedge clk) disable iff (rst)
      aprFlags[32] == expReq && aprIntr == expIntr)
      else
      begin
         failCount++;
         $error("Error %0t aprFlags[32]/aprIntr expected %b/%b got %b/%b", $time,
                $sampled(expReq), $sampled(expIntr), $sampled(aprFlags[32]), $sampled(aprIntr));
      end

   piArbitrate: assert property (@(posedge clk) disable iff (rst)
      clkenQ |-> (piLevel == expLevelQ && piReq == (expLevelQ != 3'd0)))
      else
      begin
         failCount++;
         $error("Error %0t piLevel/piReq expected %0d/%b got %0d/%b", $time,
                $sampled(expLevelQ), $sampled(expLevelQ != 3'd0), $sampled(piLevel),
                $sampled(piReq));
      end

   // Frozen while clken is low
   piHold: assert property (@(posedge clk) disable iff (rst)
      !clkenQ |-> (piLevel == prevLevel && piReq == prevReq))
      else
      begin
         failCount++;
         $error("Error %0t piLevel/piReq held expected %0d/%b got %0d/%b", $time,
                $sampled(prevLevel), $sampled(prevReq), $sampled(piLevel), $sampled(piReq));
      end

endmodule

// ==== hw/aprSubsystem.sv ====
`include "ks10_macros.svh"

// APR status block with its priority interrupt stage
module aprSubsystem
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  clken,
   input  logic [0:`CROM_WIDTH-1] crom,
   input  ks10_pkg::dpWord_t      dp,
   input  logic                  nxmIntr,
   input  logic                  cslIntr,
   input  logic [1:7]            devIntr,
   output logic [22:35]          aprFlags,
   output logic [1:7]            aprIntr,
   output logic                  piReq,
   output logic [0:2]            piLevel
);

   // Decoded write strobes
   logic aprEnableWr;
   logic aprFlagsWr;
   logic piEnableWr;

   //////////////////////////////////////////////////////////////////////
   // Microcode decode
   //////////////////////////////////////////////////////////////////////

   specDecode u_specDecode (.clken(clken), .crom(crom), .aprEnableWr(aprEnableWr),
                            .aprFlagsWr(aprFlagsWr), .piEnableWr(piEnableWr));

   //////////////////////////////////////////////////////////////////////
   // APR and PI
   //////////////////////////////////////////////////////////////////////

   apr u_apr (.clk(clk), .rst(rst), .aprEnableWr(aprEnableWr), .aprFlagsWr(aprFlagsWr),
              .dp(dp), .nxmIntr(nxmIntr), .cslIntr(cslIntr), .aprFlags(aprFlags),
              .aprIntr(aprIntr));

   // APR request joins the device lines here
   piArbiter u_piArbiter (.clk(clk), .rst(rst), .clken(clken), .piEnableWr(piEnableWr),
                          .dp(dp), .aprIntr(aprIntr), .devIntr(devIntr), .piReq(piReq),
                          .piLevel(piLevel));

endmodule

// ==== hw/piArbiter.sv ====
// Priority interrupt enable and level arbitration
module piArbiter
(
   input  logic             clk,
   input  logic             rst,
   input  logic             clken,
   input  logic             piEnableWr,
   input  ks10_pkg::dpWord_t dp,
   input  logic [1:7]       aprIntr,
   input  logic [1:7]       devIntr,
   output logic             piReq,
   output logic [0:2]       piLevel
);

   // PI enable register
   logic       piOn;
   logic [1:7] levelEn;

   // Merged and masked requests
   logic [1:7] masked;
   logic [0:2] nextLevel;

   //////////////////////////////////////////////////////////////////////
   // PI enable register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         piOn    <= 1'b0;
         levelEn <= '0;
      end
      else if (piEnableWr)
      begin
         piOn    <= dp.piView.piOn;
         levelEn <= dp.piView.levelEn;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Arbitration
   //////////////////////////////////////////////////////////////////////

   // APR shares the device lines, PI off kills everything
   assign masked = (aprIntr | devIntr) & levelEn & {7{piOn}};

   // Lowest-numbered level wins, scan down so it is written last
   always_comb
   begin
      nextLevel = 3'd0;
      for (int lvl = 7; lvl >= 1; lvl--)
      begin
         if (masked[lvl])
         begin
            nextLevel = 3'(lvl);
         end
      end
   end

   // Held while clken is low
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         piReq   <= 1'b0;
         piLevel <= '0;
      end
      else if (clken)
      begin
         piReq   <= |masked;
         piLevel <= nextLevel;
      end
   end

endmodule

// ==== hw/apr.sv ====
// APR status flags, enables and interrupt request
module apr
(
   input  logic             clk,
   input  logic             rst,
   input  logic             aprEnableWr,
   input  logic             aprFlagsWr,
   input  ks10_pkg::dpWord_t dp,
   input  logic             nxmIntr,
   input  logic             cslIntr,
   output logic [22:35]     aprFlags,
   output logic [1:7]       aprIntr
);

   // Flag register
   logic [24:31] flags;

   // Enable register
   logic         trapEn;
   logic         pageEn;
   logic [24:31] enMask;
   logic         swInt;
   logic [0:2]   pri;

   // Combined request before level decode
   logic         intReq;

   //////////////////////////////////////////////////////////////////////
   // Flag register
   //////////////////////////////////////////////////////////////////////

   // Flag 27 is non-existent memory
   // Flag 31 is the console request
   // Event sets land after the write so they win
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         flags <= '0;
      end
      else
      begin
         if (aprFlagsWr)
         begin
            flags <= dp.aprFlagView.flags;
         end
         if (nxmIntr)
         begin
            flags[27] <= 1'b1;
         end
         if (cslIntr)
         begin
            flags[31] <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Enable register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trapEn <= 1'b0;
         pageEn <= 1'b0;
         enMask <= '0;
         swInt  <= 1'b0;
         pri    <= '0;
      end
      else if (aprEnableWr)
      begin
         trapEn <= dp.aprEnView.trapEn;
         pageEn <= dp.aprEnView.pageEn;
         enMask <= dp.aprEnView.mask;
         swInt  <= dp.aprEnView.swInt;
         pri    <= dp.aprEnView.pri;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Request and level decode
   //////////////////////////////////////////////////////////////////////

   // Any enabled flag, or software request
   assign intReq = (|(flags & enMask)) | swInt;

   // One-hot on the priority level, nothing at priority 0
   always_comb
   begin
      for (int lvl = 1; lvl <= 7; lvl++)
      begin
         aprIntr[lvl] = intReq & (pri == 3'(lvl));
      end
   end

   // Status word as read back by the microcode
   assign aprFlags = {trapEn, pageEn, flags, intReq, 3'b111};

endmodule

// ==== hw/specDecode.sv ====
`include "ks10_macros.svh"

// Special field decode to register write strobes
module specDecode
(
   input  logic                  clken,
   input  logic [0:`CROM_WIDTH-1] crom,
   output logic                  aprEnableWr,
   output logic                  aprFlagsWr,
   output logic                  piEnableWr
);

   // Select field width straight from the layout
   localparam int SelWidth = `CROM_SPEC_SEL_LO - `CROM_SPEC_SEL_HI + 1;

   logic                specEn;
   logic [0:SelWidth-1] specSel;

   //////////////////////////////////////////////////////////////////////
   // Field extraction
   //////////////////////////////////////////////////////////////////////

   assign specEn  = crom[`CROM_SPEC_EN];
   assign specSel = crom[`CROM_SPEC_SEL_HI:`CROM_SPEC_SEL_LO];

   //////////////////////////////////////////////////////////////////////
   // Strobes
   //////////////////////////////////////////////////////////////////////

   // APR enable register load
   assign aprEnableWr = clken & specEn & (specSel == `SPEC_SEL_APRENABLE);

   // APR flag register load
   assign aprFlagsWr  = clken & specEn & (specSel == `SPEC_SEL_APRFLAGS);

   // PI enable register load
   assign piEnableWr  = clken & specEn & (specSel == `SPEC_SEL_PIENABLE);

endmodule

// ==== hw/ks10_pkg.sv ====
package ks10_pkg;

   // 36-bit data path word, bit 0 most significant
   // Same word is decoded differently by each register load
   typedef union packed
   {
      // APR enable register load
      struct packed
      {
         logic [0:21]  unused;
         logic         trapEn;     // Trap enable
         logic         pageEn;     // Paging enable
         logic [24:31] mask;       // Per-flag interrupt enables
         logic         swInt;      // Software interrupt
         logic [0:2]   pri;        // Request priority, 0 is off
      } aprEnView;

      // APR flag register load
      struct packed
      {
         logic [0:23]  unusedHi;
         logic [24:31] flags;
         logic [32:35] unusedLo;
      } aprFlagView;

      // PI enable register load
      struct packed
      {
         logic [0:26]  unusedHi;
         logic         piOn;       // Master enable
         logic         unused28;
         logic [1:7]   levelEn;    // Level 1 is most urgent
      } piView;
   } dpWord_t;

endpackage

// ==== hw/ks10_macros.svh ====
`ifndef KS10_MACROS_SVH
`define KS10_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Control ROM layout
//////////////////////////////////////////////////////////////////////

// Microword width, bit 0 is the most significant bit
`define CROM_WIDTH 108

// Special field enable
`define CROM_SPEC_EN 70

// Special select field, HI is the leftmost (most significant) bit
`define CROM_SPEC_SEL_HI 36
`define CROM_SPEC_SEL_LO 41

//////////////////////////////////////////////////////////////////////
// Special select codes
//////////////////////////////////////////////////////////////////////

`define SPEC_SEL_APRENABLE 6'o12
`define SPEC_SEL_APRFLAGS  6'o13
`define SPEC_SEL_PIENABLE  6'o14

`endif
